// ==== hdl/fm_spy_pkg.sv ====
// spy buffer array package: sizes, fill word, operation enums and bus structs
package fm_spy_pkg;

   localparam int num_channels = 4;                   // monitored streams
   localparam int data_w       = 32;                  // monitor word and host data width
   localparam int addr_w       = 4;                   // 16 words per capture memory

   localparam logic [data_w-1:0] fill_pattern = 32'h0fa5fa50; // init sweep word

   // per-channel memory operation decoded by the controller
   typedef enum logic [1:0] {
      op_none  = 2'b00,                               // port idle, capture may run
      op_read  = 2'b01,                               // host read into read register
      op_write = 2'b10,                               // host write
      op_fill  = 2'b11                                // init sweep write
   } spy_op_e;

   typedef enum logic {
      init_idle  = 1'b0,                              // host owns the port
      init_sweep = 1'b1                               // filling all memories
   } init_state_e;

   // monitor word with strobe, also used for passthrough
   typedef struct packed {
      logic [data_w-1:0] data;
      logic              vld;
   } mon_word_t;

   // host request levels for one channel
   typedef struct packed {
      logic              enable;                      // read strobe
      logic              wr_enable;                   // write strobe, wins over enable
      logic [addr_w-1:0] address;
      logic [data_w-1:0] wr_data;
   } spy_req_t;

   // host response for one channel
   typedef struct packed {
      logic [data_w-1:0] rd_data;                     // zero unless valid
      logic              rd_data_valid;
   } spy_rsp_t;

   // decoded memory access handed to one buffer
   typedef struct packed {
      spy_op_e           op;
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] wr_data;
   } spy_access_t;

endpackage

// ==== hdl/fm_spy_ctrl.sv ====
// spy controller: runs the init fill sweep and decodes host levels into memory operations
`timescale 1ns/1ns

module fm_spy_ctrl (
   input  logic                                                  spy_clock,
   input  logic                                                  axi_reset_n,
   input  logic                                                  init_spy_mem_i,
   input  fm_spy_pkg::spy_req_t    [fm_spy_pkg::num_channels-1:0] host_req_i,
   output fm_spy_pkg::spy_access_t [fm_spy_pkg::num_channels-1:0] access_o
);

   fm_spy_pkg::init_state_e       init_state;         // registered init request
   logic [fm_spy_pkg::addr_w-1:0] sweep_addr;         // fill address, walks upward

   // host levels to op, write has priority over read
   function automatic fm_spy_pkg::spy_op_e decode_op(input fm_spy_pkg::spy_req_t req);
      fm_spy_pkg::spy_op_e op;
      if (req.wr_enable)
      begin
         op = fm_spy_pkg::op_write;
      end
      else if (req.enable)
      begin
         op = fm_spy_pkg::op_read;
      end
      else
      begin
         op = fm_spy_pkg::op_none;
      end
      return op;
   endfunction

   always_ff @(posedge spy_clock)
   begin
      if (!axi_reset_n)
      begin
         init_state <= fm_spy_pkg::init_sweep;         // sweep held through reset
      end
      else if (init_spy_mem_i)
      begin
         init_state <= fm_spy_pkg::init_sweep;
      end
      else
      begin
         init_state <= fm_spy_pkg::init_idle;
      end
   end

   always_ff @(posedge spy_clock)
   begin
      if (!axi_reset_n)
      begin
         sweep_addr <= '0;
      end
      else if (init_state == fm_spy_pkg::init_sweep)
      begin
         sweep_addr <= sweep_addr + 1'b1;             // wraps at 16 on its own
      end
      else
      begin
         sweep_addr <= '0;                            // next sweep starts at 0
      end
   end

   // zero-cycle path from request to access
   always_comb
   begin
      for (int ch = 0; ch < fm_spy_pkg::num_channels; ch++)
      begin
         if (init_state == fm_spy_pkg::init_sweep)
         begin
            access_o[ch].op      = fm_spy_pkg::op_fill;   // host ignored while sweeping
            access_o[ch].addr    = sweep_addr;
            access_o[ch].wr_data = fm_spy_pkg::fill_pattern;
         end
         else
         begin
            access_o[ch].op      = decode_op(host_req_i[ch]);
            access_o[ch].addr    = host_req_i[ch].address;
            access_o[ch].wr_data = host_req_i[ch].wr_data;
         end
      end
   end

endmodule

// ==== hdl/fm_spy_buffer.sv ====
// spy buffer channel: circular capture memory with freeze, host port and passthrough
`timescale 1ns/1ns

module fm_spy_buffer (
   input  logic                            spy_clock,
   input  logic                            axi_reset_n,
   input  fm_spy_pkg::mon_word_t           mon_i,
   input  logic                            freeze_i,
   input  fm_spy_pkg::spy_access_t         access_i,
   output logic [fm_spy_pkg::data_w-1:0]   rd_word_o,
   output fm_spy_pkg::mon_word_t           pass_o
);

   logic [fm_spy_pkg::data_w-1:0] spy_mem [2**fm_spy_pkg::addr_w]; // capture memory
   logic [fm_spy_pkg::addr_w-1:0] cap_ptr;            // next capture address
   logic                          host_wr;            // write or fill owns the port
   logic                          cap_en;             // capture this cycle
   logic [fm_spy_pkg::data_w-1:0] pass_data;          // passthrough payload
   logic                          pass_vld;           // passthrough strobe

   assign host_wr = (access_i.op == fm_spy_pkg::op_write) ||
                    (access_i.op == fm_spy_pkg::op_fill);

   // sample dropped when host or sweep takes the port
   assign cap_en = mon_i.vld && !freeze_i && !host_wr;

   always_ff @(posedge spy_clock)
   begin
      if (!axi_reset_n)
      begin
         cap_ptr <= '0;
      end
      else if (cap_en)
      begin
         cap_ptr <= cap_ptr + 1'b1;                   // circular, wraps at 16
      end
   end

   // single write port, host side first
   always_ff @(posedge spy_clock)
   begin
      if (host_wr)
      begin
         spy_mem[access_i.addr] <= access_i.wr_data;
      end
      else if (cap_en)
      begin
         spy_mem[cap_ptr] <= mon_i.data;
      end
   end

   // host read, one cycle
   always_ff @(posedge spy_clock)
   begin
      if (access_i.op == fm_spy_pkg::op_read)
      begin
         rd_word_o <= spy_mem[access_i.addr];         // old word if capture hits same addr
      end
   end

   always_ff @(posedge spy_clock)
   begin
      if (!axi_reset_n)
      begin
         pass_vld <= 1'b0;
      end
      else
      begin
         pass_vld <= mon_i.vld;                       // forwarded frozen or not
      end
   end

   always_ff @(posedge spy_clock)
   begin
      pass_data <= mon_i.data;
   end

   assign pass_o = '{data: pass_data, vld: pass_vld};

endmodule

// ==== hdl/fm_spy_readback.sv ====
// spy readback: registers read valids and zero-gates the host responses
`timescale 1ns/1ns

module fm_spy_readback (
   input  logic                                                   spy_clock,
   input  logic                                                   axi_reset_n,
   input  fm_spy_pkg::spy_op_e [fm_spy_pkg::num_channels-1:0]     op_i,
   input  logic [fm_spy_pkg::num_channels-1:0][fm_spy_pkg::data_w-1:0] rd_word_i,
   output fm_spy_pkg::spy_rsp_t [fm_spy_pkg::num_channels-1:0]    host_rsp_o
);

   logic [fm_spy_pkg::num_channels-1:0] rd_vld;       // one per channel

   // valid lines up with the buffer read register
   always_ff @(posedge spy_clock)
   begin
      if (!axi_reset_n)
      begin
         rd_vld <= '0;
      end
      else
      begin
         for (int ch = 0; ch < fm_spy_pkg::num_channels; ch++)
         begin
            rd_vld[ch] <= (op_i[ch] == fm_spy_pkg::op_read);
         end
      end
   end

   always_comb
   begin
      for (int ch = 0; ch < fm_spy_pkg::num_channels; ch++)
      begin
         host_rsp_o[ch].rd_data_valid = rd_vld[ch];
         host_rsp_o[ch].rd_data       = rd_vld[ch] ? rd_word_i[ch] : '0; // stale word hidden
      end
   end

endmodule

// ==== hdl/fm_spy_top.sv ====
// spy buffer array top: controller, one capture buffer per channel and host readback
`timescale 1ns/1ns

module fm_spy_top (
   input  logic                                                  spy_clock,
   input  logic                                                  axi_reset_n,
   input  logic                                                  init_spy_mem_i,
   input  logic [fm_spy_pkg::num_channels-1:0]                   freeze_i,
   input  fm_spy_pkg::mon_word_t   [fm_spy_pkg::num_channels-1:0] mon_i,
   input  fm_spy_pkg::spy_req_t    [fm_spy_pkg::num_channels-1:0] host_req_i,
   output fm_spy_pkg::spy_rsp_t    [fm_spy_pkg::num_channels-1:0] host_rsp_o,
   output fm_spy_pkg::mon_word_t   [fm_spy_pkg::num_channels-1:0] pass_o
);

   fm_spy_pkg::spy_access_t [fm_spy_pkg::num_channels-1:0]    access;    // decoded ops
   fm_spy_pkg::spy_op_e     [fm_spy_pkg::num_channels-1:0]    access_op; // op field only
   logic [fm_spy_pkg::num_channels-1:0][fm_spy_pkg::data_w-1:0] rd_word; // read registers

   fm_spy_ctrl u_ctrl (
      .spy_clock      (spy_clock),
      .axi_reset_n    (axi_reset_n),
      .init_spy_mem_i (init_spy_mem_i),
      .host_req_i     (host_req_i),
      .access_o       (access)
   );

   for (genvar ch = 0; ch < fm_spy_pkg::num_channels; ch++)
   begin : g_buf
      assign access_op[ch] = access[ch].op;

      fm_spy_buffer u_buffer (
         .spy_clock   (spy_clock),
         .axi_reset_n (axi_reset_n),
         .mon_i       (mon_i[ch]),
         .freeze_i    (freeze_i[ch]),
         .access_i    (access[ch]),
         .rd_word_o   (rd_word[ch]),
         .pass_o      (pass_o[ch])
      );
   end

   fm_spy_readback u_readback (
      .spy_clock   (spy_clock),
      .axi_reset_n (axi_reset_n),
      .op_i        (access_op),
      .rd_word_i   (rd_word),
      .host_rsp_o  (host_rsp_o)
   );

endmodule

// ==== verif/fm_spy_assertions.sv ====
// readback protocol checks: read valid timing, zero gating and no read during the fill sweep
`timescale 1ns/1ns

module fm_spy_assertions (
   input logic                                               spy_clock,
   input logic                                               axi_reset_n,
   input fm_spy_pkg::spy_op_e  [fm_spy_pkg::num_channels-1:0] op_i,
   input fm_spy_pkg::spy_rsp_t [fm_spy_pkg::num_channels-1:0] host_rsp_i
);

   int unsigned                         error_count = 0; // polled by the testbench
   logic [fm_spy_pkg::num_channels-1:0] is_read;
   logic [fm_spy_pkg::num_channels-1:0] is_fill;

   always_comb
   begin
      for (int ch = 0; ch < fm_spy_pkg::num_channels; ch++)
      begin
         is_read[ch] = (op_i[ch] == fm_spy_pkg::op_read);
         is_fill[ch] = (op_i[ch] == fm_spy_pkg::op_fill);
      end
   end

   for (genvar ch = 0; ch < fm_spy_pkg::num_channels; ch++)
   begin : g_chk
      a_valid_after_read : assert property (@(posedge spy_clock) disable iff (!axi_reset_n)
         $rose(host_rsp_i[ch].rd_data_valid) |-> $past(is_read[ch]))
         else
         begin
            $error("rd_data_valid rose without a read one cycle earlier");
            error_count++;
         end

      a_zero_when_idle : assert property (@(posedge spy_clock) disable iff (!axi_reset_n)
         !host_rsp_i[ch].rd_data_valid |-> (host_rsp_i[ch].rd_data == '0))
         else
         begin
            $error("rd_data not zero while rd_data_valid is low");
            error_count++;
         end
   end

   // sweep owns every port, so a read next to a fill means the decode leaked
   a_no_read_in_sweep : assert property (@(posedge spy_clock) disable iff (!axi_reset_n)
      !((|is_read) && (|is_fill)))
      else
      begin
         $error("op_read seen while op_fill active");
         error_count++;
      end

endmodule

bind fm_spy_readback fm_spy_assertions u_assertions (
   .spy_clock   (spy_clock),
   .axi_reset_n (axi_reset_n),
   .op_i        (op_i),
   .host_rsp_i  (host_rsp_o)
);

// ==== verif/fm_spy_tb.sv ====
// spy buffer array testbench: init sweep, host access, capture, freeze and passthrough checks
`timescale 1ns/1ns

module fm_spy_tb;

   localparam int nch          = fm_spy_pkg::num_channels;
   localparam int depth        = 2**fm_spy_pkg::addr_w;
   localparam int read_timeout = 8;                   // cycles allowed for rd_data_valid

   logic                            spy_clock    = 1'b0;
   logic                            axi_reset_n  = 1'b0;
   logic                            init_spy_mem = 1'b0;
   logic [nch-1:0]                  freeze       = '1; // all frozen until capture
   fm_spy_pkg::mon_word_t [nch-1:0] mon          = '1; // valid held high through reset
   fm_spy_pkg::spy_req_t  [nch-1:0] host_req     = '0;
   fm_spy_pkg::spy_rsp_t  [nch-1:0] host_rsp;
   fm_spy_pkg::mon_word_t [nch-1:0] pass;

   logic [fm_spy_pkg::data_w-1:0] m_mem [nch][depth]; // reference memories
   logic [fm_spy_pkg::addr_w-1:0] m_ptr [nch];        // reference capture pointers
   logic [fm_spy_pkg::data_w-1:0] m_rd_word [nch];
   logic [nch-1:0]                m_rd_vld;
   fm_spy_pkg::mon_word_t         m_pass [nch];
   logic                          m_sweep      = 1'b0;
   logic [fm_spy_pkg::addr_w-1:0] m_sweep_addr = '0;
   int                            edges_seen   = 0;

   fm_spy_pkg::spy_rsp_t          exp_rsp;
   logic [fm_spy_pkg::data_w-1:0] rd_data;            // last host read result
   logic [fm_spy_pkg::data_w-1:0] word;
   logic [fm_spy_pkg::data_w-1:0] snap [depth];       // memory before the frozen feed
   logic [fm_spy_pkg::data_w-1:0] resumed [$];        // words fed after unfreeze
   logic [fm_spy_pkg::addr_w-1:0] addr;
   logic [fm_spy_pkg::addr_w-1:0] start_ptr;
   int                            ch_sel;
   int                            waited;
   int                            mch;

   fm_spy_top uut (
      .spy_clock      (spy_clock),
      .axi_reset_n    (axi_reset_n),
      .init_spy_mem_i (init_spy_mem),
      .freeze_i       (freeze),
      .mon_i          (mon),
      .host_req_i     (host_req),
      .host_rsp_o     (host_rsp),
      .pass_o         (pass)
   );

   always #5 spy_clock = ~spy_clock;                  // 10 ns period

   task fail_run(input string msg);
      $display("%s", msg);
      $display(">>> FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task report_mismatch(input string sig, input logic [63:0] exp_v, input logic [63:0] act_v);
      fail_run($sformatf("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                         $time, sig, exp_v, act_v));
   endtask

   // one clock edge of the array: ctrl decode, memory, pointers, read and pass registers
   function void model_edge();
      fm_spy_pkg::spy_op_e           op;
      logic [fm_spy_pkg::addr_w-1:0] a;
      logic [fm_spy_pkg::data_w-1:0] wd;
      for (int ch = 0; ch < nch; ch++)
      begin
         op = fm_spy_pkg::op_none;
         a  = host_req[ch].address;
         wd = host_req[ch].wr_data;
         if (m_sweep)
         begin
            op = fm_spy_pkg::op_fill;                 // host ignored in sweep
            a  = m_sweep_addr;
            wd = fm_spy_pkg::fill_pattern;
         end
         else if (host_req[ch].wr_enable)
            op = fm_spy_pkg::op_write;
         else if (host_req[ch].enable)
            op = fm_spy_pkg::op_read;
         if (op == fm_spy_pkg::op_read)
            m_rd_word[ch] = m_mem[ch][a];             // old word before any write
         if (op == fm_spy_pkg::op_write || op == fm_spy_pkg::op_fill)
            m_mem[ch][a] = wd;                        // capture sample dropped
         else if (mon[ch].vld && !freeze[ch])
         begin
            m_mem[ch][m_ptr[ch]] = mon[ch].data;
            m_ptr[ch]            = m_ptr[ch] + 1'b1;  // wraps at 16
         end
         if (!axi_reset_n)
            m_ptr[ch] = '0;
         m_rd_vld[ch]    = axi_reset_n && (op == fm_spy_pkg::op_read);
         m_pass[ch].vld  = axi_reset_n && mon[ch].vld;
         m_pass[ch].data = mon[ch].data;
      end
      if (!axi_reset_n)
         m_sweep_addr = '0;
      else
         m_sweep_addr = m_sweep ? m_sweep_addr + 1'b1 : '0;
      m_sweep = !axi_reset_n || init_spy_mem;         // sweep through reset, then request
      edges_seen++;
   endfunction

   always @(posedge spy_clock)
      model_edge();

   // outputs settle after the rising edge, compare in the middle of the cycle
   always @(negedge spy_clock)
   begin
      if (edges_seen > 0)
      begin
         for (int ch = 0; ch < nch; ch++)
         begin
            exp_rsp.rd_data_valid = m_rd_vld[ch];
            exp_rsp.rd_data       = m_rd_vld[ch] ? m_rd_word[ch] : '0;
            assert (host_rsp[ch] === exp_rsp)
               else report_mismatch($sformatf("host_rsp_o[%0d]", ch), exp_rsp, host_rsp[ch]);
            assert (pass[ch] === m_pass[ch])
               else report_mismatch($sformatf("pass_o[%0d]", ch), m_pass[ch], pass[ch]);
         end
         assert (uut.u_readback.u_assertions.error_count == 0)
            else fail_run("a bound protocol assertion on the readback failed");
      end
   end

   // random words on every channel, hot_ch always valid
   task drive_mon(input int hot_ch);
      for (mch = 0; mch < nch; mch++)
         mon[mch] <= '{data: $urandom, vld: (mch == hot_ch) || ($urandom % 3 != 0)};
   endtask

   task host_write(input int ch, input logic [fm_spy_pkg::addr_w-1:0] a,
                   input logic [fm_spy_pkg::data_w-1:0] d);
      @(posedge spy_clock);
      host_req[ch] <= '{enable: 1'b0, wr_enable: 1'b1, address: a, wr_data: d};
      @(posedge spy_clock);
      host_req[ch] <= '0;
   endtask

   // one-cycle read enable, then wait for the valid response
   task host_read(input int ch, input logic [fm_spy_pkg::addr_w-1:0] a);
      @(posedge spy_clock);
      host_req[ch] <= '{enable: 1'b1, wr_enable: 1'b0, address: a, wr_data: '0};
      @(posedge spy_clock);
      host_req[ch] <= '0;
      waited = 0;
      @(negedge spy_clock);
      while (!host_rsp[ch].rd_data_valid)
      begin
         if (waited == read_timeout)
            fail_run("no read response arrived within the timeout");
         else
         begin
            waited++;
            @(negedge spy_clock);
         end
      end
      assert (waited == 0) else fail_run("read response was not one cycle after the enable");
      rd_data = host_rsp[ch].rd_data;
   endtask

   initial
   begin
      void'($urandom(32'h900c9ee8));                  // one seed for the whole run
      repeat (4) @(posedge spy_clock);
      axi_reset_n <= 1'b1;
      mon         <= '0;
      @(negedge spy_clock);
      for (int ch = 0; ch < nch; ch++)
         assert (!pass[ch].vld) else fail_run("pass valid was high right after reset");

      // init sweep covers every address
      @(posedge spy_clock);
      init_spy_mem <= 1'b1;
      repeat (20) @(posedge spy_clock);
      init_spy_mem <= 1'b0;
      for (int ch = 0; ch < nch; ch++)
         for (int a = 0; a < depth; a++)
         begin
            host_read(ch, a);
            assert (rd_data === fm_spy_pkg::fill_pattern)
               else report_mismatch("host_rsp_o.rd_data", fm_spy_pkg::fill_pattern, rd_data);
         end

      // host write then read back, frozen channels
      repeat (12)
      begin
         ch_sel = $urandom % nch;
         addr   = $urandom;
         word   = $urandom;
         host_write(ch_sel, addr, word);
         host_read(ch_sel, addr);
         assert (rd_data === word) else report_mismatch("host_rsp_o.rd_data", word, rd_data);
         repeat ($urandom % 3) @(posedge spy_clock);  // idle gap
      end

      // capture on one channel, gaps included
      ch_sel = $urandom % nch;
      @(posedge spy_clock);
      freeze[ch_sel] <= 1'b0;
      repeat (20 + $urandom % 12)
      begin
         @(posedge spy_clock);
         drive_mon(-1);
      end
      @(posedge spy_clock);
      mon    <= '0;
      freeze <= '1;
      for (int a = 0; a < depth; a++)
      begin
         host_read(ch_sel, a);
         assert (rd_data === m_mem[ch_sel][a])
            else report_mismatch("host_rsp_o.rd_data", m_mem[ch_sel][a], rd_data);
      end

      // frozen channel keeps memory and pointer
      snap      = m_mem[ch_sel];
      start_ptr = m_ptr[ch_sel];
      repeat (8)
      begin
         @(posedge spy_clock);
         drive_mon(ch_sel);
      end
      @(posedge spy_clock);
      mon <= '0;
      for (int a = 0; a < depth; a++)
      begin
         host_read(ch_sel, a);
         assert (rd_data === snap[a]) else report_mismatch("host_rsp_o.rd_data", snap[a], rd_data);
      end
      @(posedge spy_clock);
      freeze[ch_sel] <= 1'b0;
      repeat (3)
      begin
         @(posedge spy_clock);
         word = $urandom;
         resumed.push_back(word);
         mon[ch_sel] <= '{data: word, vld: 1'b1};
      end
      @(posedge spy_clock);
      mon    <= '0;
      freeze <= '1;
      foreach (resumed[i])
      begin
         host_read(ch_sel, start_ptr + i);            // resumes at the held pointer
         assert (rd_data === resumed[i])
            else report_mismatch("host_rsp_o.rd_data", resumed[i], rd_data);
      end

      repeat (2) @(posedge spy_clock);
      if (uut.u_readback.u_assertions.error_count == 0)
      begin
         $display(">>> PASS");
         $finish;
      end
      else
         fail_run("a bound protocol assertion on the readback failed");
   end

endmodule

// ==== flist.f ====
hdl/fm_spy_pkg.sv
hdl/fm_spy_ctrl.sv
hdl/fm_spy_buffer.sv
hdl/fm_spy_readback.sv
hdl/fm_spy_top.sv
verif/fm_spy_assertions.sv
verif/fm_spy_tb.sv

// ==== Bender.yml ====
package:
  name: fm_spy

sources:
  - hdl/fm_spy_pkg.sv
  - hdl/fm_spy_ctrl.sv
  - hdl/fm_spy_buffer.sv
  - hdl/fm_spy_readback.sv
  - hdl/fm_spy_top.sv
  - target: test
    files:
      - verif/fm_spy_assertions.sv
      - verif/fm_spy_tb.sv
